// ==== Makefile ====
# Verilator simulation of the PC Engine cart loader

VERILATOR ?= verilator
TOP       ?= tb_pce_cart_loader
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/pce_loader_pkg.sv
src/load_stream_decode.sv
src/rom_write_issue.sv
src/populous_detect.sv
src/cheat_code_packer.sv
src/pce_cart_loader.sv
verif/ack_responder.sv
verif/tb_pce_cart_loader.sv

// ==== src/cheat_code_packer.sv ====
`timescale 1ns/1ps

module cheat_code_packer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_loader_pkg::load_beat_t  beat,
	output pce_loader_pkg::cheat_code_t cheat,
	output logic                        code_valid,
	output logic                        gg_reset
);
	import pce_loader_pkg::*;

	cheat_code_t code_q;

	// Low word of each field first, then high word
	always_ff @(posedge clk_sys) begin
		if (beat.code_wr) begin
			case (beat.offset)
				4'd0:  code_q.flags[15:0]    <= beat.data;
				4'd2:  code_q.flags[31:16]   <= beat.data;
				4'd4:  code_q.address[15:0]  <= beat.data;
				4'd6:  code_q.address[31:16] <= beat.data;
				4'd8:  code_q.compare[15:0]  <= beat.data;
				4'd10: code_q.compare[31:16] <= beat.data;
				4'd12: code_q.replace[15:0]  <= beat.data;
				4'd14: code_q.replace[31:16] <= beat.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			gg_reset   <= 1'b0;
		end else begin
			code_valid <= beat.code_wr && (beat.offset == 4'd14);   // Last word in
			gg_reset   <= (beat.cart_wr | beat.code_wr) & beat.first_word;
		end
	end

	assign cheat = code_q;

	// One strobe per code, since offset 14 comes once per eight words
	a_single_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid)
		else $error("code_valid held high for two cycles");

endmodule

// ==== src/load_stream_decode.sv ====
`timescale 1ns/1ps

module load_stream_decode (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_loader_pkg::host_xfer_t host,
	input  logic                       swap_en,
	output pce_loader_pkg::load_beat_t beat,
	output logic                       cart_start,
	output logic                       sgx
);
	import pce_loader_pkg::*;

	logic              code_index;
	logic              cart_dl;
	logic              cart_dl_q;
	logic [WORD_W-1:0] data_rev;
	logic [WORD_W-1:0] data_d;
	logic              cart_wr_q;
	logic              code_wr_q;
	logic              first_q;
	logic [3:0]        offset_q;
	logic [WORD_W-1:0] data_q;

	assign code_index = (host.index == CODE_INDEX);
	assign cart_dl    = host.download & ~code_index;

	// Mirror bits inside each byte
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			data_rev[i]     = host.data[7 - i];
			data_rev[8 + i] = host.data[15 - i];
		end
	end

	assign data_d = (swap_en && !code_index) ? data_rev : host.data;   // Codes stay as sent

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_wr_q  <= 1'b0;
			code_wr_q  <= 1'b0;
			cart_dl_q  <= 1'b0;
			cart_start <= 1'b0;
			sgx        <= 1'b0;
		end else begin
			cart_wr_q  <= host.wr & cart_dl;
			code_wr_q  <= host.wr & host.download & code_index;
			cart_dl_q  <= cart_dl;
			cart_start <= cart_dl & ~cart_dl_q;   // Start of a cart download
			if (cart_dl && !cart_dl_q)
				sgx <= (host.index[4:0] == SGX_INDEX);
		end
	end

	always_ff @(posedge clk_sys) begin
		first_q  <= (host.addr == '0);
		offset_q <= host.addr[3:0];
		data_q   <= data_d;
	end

	assign beat = '{cart_wr: cart_wr_q, code_wr: code_wr_q, first_word: first_q,
		offset: offset_q, data: data_q};

	// Host holds off until the wait level has risen, so no write lands
	// while the previous cart beat is still on its way to the memories
	a_no_write_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr_q |-> !host.wr)
		else $error("host write arrived while a cart beat was pending");

endmodule

// ==== src/pce_cart_loader.sv ====
`timescale 1ns/1ps

module pce_cart_loader #(
	parameter int NUM_MEM = 2
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_loader_pkg::host_xfer_t  host,
	input  logic                        swap_en,
	output pce_loader_pkg::rom_write_t  rom_wr,
	output logic                        rom_req,
	input  logic [NUM_MEM-1:0]          rom_ack,
	output logic                        ioctl_wait,
	output pce_loader_pkg::cart_info_t  info,
	output pce_loader_pkg::cheat_code_t cheat,
	output logic                        code_valid,
	output logic                        gg_reset
);
	import pce_loader_pkg::*;

	load_beat_t beat;
	logic       cart_start;
	logic       sgx;
	logic       issued;
	logic       populous;
	logic [7:0] rom_size;

	// ========================================================================
	// Cart path
	// ========================================================================
	load_stream_decode u_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host       (host),
		.swap_en    (swap_en),
		.beat       (beat),
		.cart_start (cart_start),
		.sgx        (sgx)
	);

	rom_write_issue #(
		.NUM_MEM (NUM_MEM)
	) u_issue (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat       (beat),
		.cart_start (cart_start),
		.rom_ack    (rom_ack),
		.rom_wr     (rom_wr),
		.rom_req    (rom_req),
		.ioctl_wait (ioctl_wait),
		.issued     (issued),
		.rom_size   (rom_size)
	);

	populous_detect u_populous (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_start (cart_start),
		.issued     (issued),
		.rom_wr     (rom_wr),
		.populous   (populous)
	);

	// Code path
	cheat_code_packer u_codes (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat       (beat),
		.cheat      (cheat),
		.code_valid (code_valid),
		.gg_reset   (gg_reset)
	);

	assign info = '{sgx: sgx, populous: populous, rom_size: rom_size};

endmodule

// ==== src/pce_loader_pkg.sv ====
package pce_loader_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int ROM_ADDR_W  = 24;   // ROM byte address
	localparam int HOST_ADDR_W = 25;   // Host byte address
	localparam int WORD_W      = 16;

	// Download index values
	localparam logic [7:0] CODE_INDEX = 8'hFF;    // Cheat code download
	localparam logic [4:0] SGX_INDEX  = 5'd2;     // SuperGrafx image, low index bits

	// ========================================================================
	// Populous title signature
	// ========================================================================
	// Window bases compare against address bits 23:4
	localparam logic [19:0] TITLE_WIN_PLAIN = 20'h1F2;
	localparam logic [19:0] TITLE_WIN_HDR   = 20'h212;   // Behind a 512 byte copier header

	// Entry 0 sits at window offset 6, then every second byte
	localparam logic [3:0][WORD_W-1:0] POP_SIG = {16'h5355, 16'h4F4C, 16'h5550, 16'h4F50};

	// ========================================================================
	// Bundles
	// ========================================================================
	typedef struct packed {
		logic                   download;
		logic [7:0]             index;
		logic                   wr;
		logic [HOST_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]      data;
	} host_xfer_t;

	typedef struct packed {
		logic              cart_wr;
		logic              code_wr;
		logic              first_word;   // Host address was zero
		logic [3:0]        offset;
		logic [WORD_W-1:0] data;         // Byte swap already applied on cart beats
	} load_beat_t;

	typedef struct packed {
		logic [ROM_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} rom_write_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic       sgx;
		logic       populous;
		logic [7:0] rom_size;
	} cart_info_t;

endpackage

// ==== src/populous_detect.sv ====
`timescale 1ns/1ps

module populous_detect (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       cart_start,
	input  logic                       issued,
	input  pce_loader_pkg::rom_write_t rom_wr,
	output logic                       populous
);
	import pce_loader_pkg::*;

	logic [1:0] pop_q;      // Bit 0 plain image, bit 1 with copier header
	logic       in_win;
	logic       sig_slot;
	logic [1:0] sig_idx;
	logic       mismatch;

	assign in_win = (rom_wr.addr[23:4] == TITLE_WIN_PLAIN) ||
		(rom_wr.addr[23:4] == TITLE_WIN_HDR);

	// Only four offsets in the window carry signature words
	always_comb begin
		sig_slot = 1'b1;
		sig_idx  = 2'd0;
		case (rom_wr.addr[3:0])
			4'd6:    sig_idx = 2'd0;
			4'd8:    sig_idx = 2'd1;
			4'd10:   sig_idx = 2'd2;
			4'd12:   sig_idx = 2'd3;
			default: sig_slot = 1'b0;
		endcase
	end

	assign mismatch = in_win & sig_slot & (rom_wr.data != POP_SIG[sig_idx]);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pop_q <= 2'b11;
		end else if (cart_start) begin
			pop_q <= 2'b11;   // Assume a match until a word disagrees
		end else if (issued && mismatch) begin
			pop_q[rom_wr.addr[13]] <= 1'b0;
		end
	end

	// Bit 9 of the size tells whether a 512 byte header was loaded
	assign populous = pop_q[rom_wr.addr[9]];

endmodule

// ==== src/rom_write_issue.sv ====
`timescale 1ns/1ps

module rom_write_issue #(
	parameter int NUM_MEM = 2
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_loader_pkg::load_beat_t beat,
	input  logic                       cart_start,
	input  logic [NUM_MEM-1:0]         rom_ack,
	output pce_loader_pkg::rom_write_t rom_wr,
	output logic                       rom_req,
	output logic                       ioctl_wait,
	output logic                       issued,
	output logic [7:0]                 rom_size
);
	import pce_loader_pkg::*;

	logic [ROM_ADDR_W-1:0] addr_q;
	logic [WORD_W-1:0]     data_q;
	logic                  all_acked;
	logic                  advance;

	// ========================================================================
	// Toggle handshake
	// ========================================================================
	// Each memory is done once its ack toggle has caught up with the request
	assign all_acked = (rom_ack == {NUM_MEM{rom_req}});
	assign advance   = ioctl_wait & all_acked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			addr_q     <= '0;
			rom_req    <= 1'b0;
			ioctl_wait <= 1'b0;
			issued     <= 1'b0;
		end else begin
			issued <= beat.cart_wr;
			if (beat.cart_wr) begin
				rom_req    <= ~rom_req;   // New word for every memory
				ioctl_wait <= 1'b1;
			end else if (advance) begin
				ioctl_wait <= 1'b0;
			end

			// Byte address steps two bytes per word
			if (cart_start)
				addr_q <= '0;
			else if (advance)
				addr_q <= addr_q + ROM_ADDR_W'(2);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (beat.cart_wr)
			data_q <= beat.data;
	end

	assign rom_wr   = '{addr: addr_q, data: data_q};
	assign rom_size = addr_q[ROM_ADDR_W-1:ROM_ADDR_W-8];   // 64 KB units

	// ========================================================================
	// Protocol checks
	// ========================================================================
	a_beat_while_busy: assert property (@(posedge clk_sys) disable iff (reset)
		beat.cart_wr |-> !ioctl_wait)
		else $error("cart beat arrived while memories were still busy");

	// Memories only answer an outstanding request
	a_ack_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(!ioctl_wait && !beat.cart_wr) |=> $stable(rom_ack))
		else $error("acknowledge changed with no request pending");

endmodule

// ==== verif/ack_responder.sv ====
`timescale 1ns/1ps

module ack_responder (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       rom_req,
	input  pce_loader_pkg::rom_write_t rom_wr,
	output logic                       ack
);
	import pce_loader_pkg::*;

	rom_write_t  received[$];   // Every word seen on a request edge
	logic        req_seen;
	logic        busy;
	int unsigned delay;

	initial begin
		ack      = 1'b0;
		req_seen = 1'b0;
		busy     = 1'b0;
		delay    = 0;
	end

	// Memory side answers on the falling edge
	always @(negedge clk_sys) begin
		if (reset) begin
			ack      <= 1'b0;
			req_seen <= 1'b0;
			busy     <= 1'b0;
			delay    <= 0;
		end else if (rom_req != req_seen) begin
			received.push_back(rom_wr);
			req_seen <= rom_req;
			busy     <= 1'b1;
			delay    <= $urandom_range(7, 0);   // Slow memory model
		end else if (busy) begin
			if (delay == 0) begin
				ack  <= req_seen;
				busy <= 1'b0;
			end else begin
				delay <= delay - 1;
			end
		end
	end

endmodule

// ==== verif/tb_pce_cart_loader.sv ====
`timescale 1ns/1ps

module tb_pce_cart_loader;
	import pce_loader_pkg::*;

	logic        clk_sys;
	logic        reset;
	host_xfer_t  host;
	logic        swap_en;
	rom_write_t  rom_wr;
	logic        rom_req;
	logic [1:0]  rom_ack;
	logic        ioctl_wait;
	cart_info_t  info;
	cheat_code_t cheat;
	logic        code_valid;
	logic        gg_reset;

	int          errors;
	int          gg_count;
	int          gg_expected;
	int          valid_count;
	logic        code_phase;
	logic [15:0] sent[$];   // Expected data per word of the current load

	pce_cart_loader #(.NUM_MEM(2)) u_dut (
		.clk_sys(clk_sys), .reset(reset), .host(host), .swap_en(swap_en),
		.rom_wr(rom_wr), .rom_req(rom_req), .rom_ack(rom_ack),
		.ioctl_wait(ioctl_wait), .info(info), .cheat(cheat),
		.code_valid(code_valid), .gg_reset(gg_reset)
	);

	ack_responder u_ack0 (.clk_sys(clk_sys), .reset(reset), .rom_req(rom_req),
		.rom_wr(rom_wr), .ack(rom_ack[0]));
	ack_responder u_ack1 (.clk_sys(clk_sys), .reset(reset), .rom_req(rom_req),
		.rom_wr(rom_wr), .ack(rom_ack[1]));

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Protocol checks
	// ========================================================================
	a_req_timing: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && host.download && host.index != CODE_INDEX) |-> ##2 $changed(rom_req))
		else begin
			errors++;
			$display("Request did not toggle two cycles after a host write");
		end

	a_wait_release: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ioctl_wait) |-> $past(rom_ack == {2{rom_req}}))
		else begin
			errors++;
			$display("Wait level fell before both memories acknowledged");
		end

	a_code_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		code_phase |-> (!ioctl_wait && $stable(rom_req)))
		else begin
			errors++;
			$display("Code download raised the wait level or toggled the request");
		end

	always @(posedge clk_sys) begin
		if (!reset && gg_reset)
			gg_count++;
		if (!reset && code_valid)
			valid_count++;
	end

	task automatic report_mismatch(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		errors++;
		$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
	endtask

	function automatic logic [15:0] mirror_bytes(input logic [15:0] w);
		logic [15:0] r;
		for (int b = 0; b < 16; b++)
			r[b] = w[(b / 8) * 8 + 7 - (b % 8)];
		return r;
	endfunction

	// Title words at 1F26..1F2C carry the signature, the rest a pattern
	function automatic logic [15:0] image_word(input logic [23:0] a, input bit corrupt);
		case (a)
			24'h1F26: return 16'h4F50;
			24'h1F28: return 16'h5550;
			24'h1F2A: return corrupt ? 16'h4E4C : 16'h4F4C;
			24'h1F2C: return 16'h5355;
			default:  return a[15:0] ^ {a[7:0], a[15:8]} ^ {a[23:16], 8'h3A};
		endcase
	endfunction

	task automatic wait_level(input logic value, input string what);
		int n;
		for (n = 0; n < 100; n++) begin
			@(negedge clk_sys);
			if (ioctl_wait == value)
				break;
		end
		if (n == 100) begin
			errors++;
			$display("Timed out waiting for the wait level to %s", what);
		end
	endtask

	task automatic host_write(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		host.wr   = 1'b1;
		host.addr = addr;
		host.data = data;
		if (addr == '0)
			gg_expected++;
		@(negedge clk_sys);
		host.wr = 1'b0;
	endtask

	// Mode 0 random words, 1 clean image, 2 image with a bad signature word
	task automatic load_cart(input string name, input logic [7:0] index, input int words,
			input logic swap, input int mode);
		int         base;
		logic [15:0] w;
		sent.delete();
		base = u_ack0.received.size();
		@(negedge clk_sys);
		swap_en       = swap;
		host.index    = index;
		host.download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int n = 0; n < words; n++) begin
			w = (mode == 0) ? 16'($urandom) : image_word(24'(2 * n), mode == 2);
			sent.push_back(swap ? mirror_bytes(w) : w);
			host_write(25'(2 * n), w);
			wait_level(1'b1, "rise");
			wait_level(1'b0, "fall");
		end
		@(negedge clk_sys);
		host.download = 1'b0;
		repeat (2) @(negedge clk_sys);
		assert (u_ack0.received.size() - base == words && u_ack1.received.size() - base == words)
			else report_mismatch({name, " word count"}, words, u_ack0.received.size() - base);
		for (int n = 0; n < words; n++) begin
			assert (u_ack0.received[base + n].addr == 24'(2 * n))
				else report_mismatch({name, " address"}, 2 * n, u_ack0.received[base + n].addr);
			assert (u_ack0.received[base + n].data == sent[n])
				else report_mismatch({name, " data"}, sent[n], u_ack0.received[base + n].data);
			assert (u_ack1.received[base + n] == u_ack0.received[base + n])
				else report_mismatch({name, " second memory"}, u_ack0.received[base + n],
					u_ack1.received[base + n]);
		end
		assert (info.rom_size == 8'((2 * words) >> 16))
			else report_mismatch({name, " rom_size"}, (2 * words) >> 16, info.rom_size);
		assert (info.sgx == (index[4:0] == 5'd2))
			else report_mismatch({name, " sgx"}, index[4:0] == 5'd2, info.sgx);
	endtask

	task automatic load_code();
		logic [15:0] w[8];
		cheat_code_t exp;
		int          start;
		int          n;
		start = valid_count;
		@(negedge clk_sys);
		swap_en       = 1'b1;   // Must not touch code data
		host.index    = 8'hFF;
		host.download = 1'b1;
		code_phase    = 1'b1;
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($urandom);
			host_write(25'(2 * i), w[i]);
		end
		for (n = 0; n < 20; n++) begin
			@(negedge clk_sys);
			if (valid_count != start)
				break;
		end
		if (n == 20) begin
			errors++;
			$display("Timed out waiting for the cheat code strobe");
		end
		repeat (3) @(negedge clk_sys);
		host.download = 1'b0;
		code_phase    = 1'b0;
		exp = '{flags: {w[1], w[0]}, address: {w[3], w[2]}, compare: {w[5], w[4]},
			replace: {w[7], w[6]}};
		assert (cheat == exp) else report_mismatch("code fields", exp, cheat);
		assert (valid_count - start == 1)
			else report_mismatch("code strobes", 1, valid_count - start);
	endtask

	initial begin
		void'($urandom(32'hb391));
		errors      = 0;
		gg_count    = 0;
		gg_expected = 0;
		valid_count = 0;
		code_phase  = 1'b0;
		host        = '0;
		swap_en     = 1'b0;
		reset       = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		load_cart("plain", 8'h00, 16, 1'b0, 0);
		load_cart("swap", 8'h02, 16, 1'b1, 0);
		load_cart("populous", 8'h01, 32768, 1'b0, 1);
		assert (info.populous == 1'b1) else report_mismatch("populous", 1, info.populous);
		load_cart("not populous", 8'h00, 4096, 1'b0, 2);
		assert (info.populous == 1'b0) else report_mismatch("not populous", 0, info.populous);
		load_code();

		// Reset while the third word of a cart load is still in flight
		@(negedge clk_sys);
		host.index    = 8'h00;
		host.download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int n = 0; n < 3; n++) begin
			host_write(25'(2 * n + 2), 16'(n));
			wait_level(1'b1, "rise");
			if (n < 2)
				wait_level(1'b0, "fall");
		end
		@(negedge clk_sys);
		reset         = 1'b1;
		host.download = 1'b0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		assert (!ioctl_wait && !rom_req && !code_valid && !gg_reset && rom_wr.addr == '0)
			else report_mismatch("reset state", 0,
				{rom_wr.addr, ioctl_wait, rom_req, code_valid, gg_reset});
		load_cart("after reset", 8'h22, 4, 1'b0, 0);

		repeat (4) @(negedge clk_sys);
		assert (gg_count == gg_expected)
			else report_mismatch("gg_reset pulses", gg_expected, gg_count);

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
